// File: files.f
common/app_pkg.sv
common/stream_if.sv
pcis_ingest/pcis_ingest.sv
verilog/ocl_csr.sv
verilog/stream_arbiter.sv
verilog/stream_fifo.sv
ddr_writer/ddr_line_writer.sv
verilog/app_top.sv
tests/app_tb.sv

// File: tests/app_tb.sv
`timescale 1ns/1ps

module app_tb;

    localparam int CLK_PERIOD = 100;
    localparam int FIFO_ADDR_WIDTH = 4;
    localparam int NUM_BURSTS = 6;
    // FIFO full of whole words plus the word held in the serializer
    localparam int HELD_WORDS = (1 << FIFO_ADDR_WIDTH) / app_pkg::BEATS_PER_LINE + 1;
    // worst case line count over all tests with DDR stalls on both channels
    localparam int MAX_LINES = 5 + NUM_BURSTS * 4 + 2;
    localparam int STIM_CYCLES = MAX_LINES * 48 + 400;

    logic clk;
    logic rstn;
    logic pcis_awvalid, pcis_awready, pcis_wvalid, pcis_wready, pcis_bvalid, pcis_bready;
    app_pkg::axi_id_t pcis_awid, pcis_bid;
    app_pkg::burst_len_t pcis_awlen;
    app_pkg::line_t pcis_wdata;
    logic ocl_awvalid, ocl_awready, ocl_wvalid, ocl_wready, ocl_bvalid, ocl_bready;
    app_pkg::csr_addr_t ocl_awaddr;
    app_pkg::csr_word_t ocl_wdata;
    logic ddr_awvalid, ddr_wvalid;
    logic ddr_awready = 1'b0;
    logic ddr_wready = 1'b0;
    app_pkg::ddr_addr_t ddr_awaddr;
    app_pkg::line_t ddr_wdata;
    logic irq_req;

    // scoreboard state
    app_pkg::beat_t exp_q[$];
    app_pkg::line_t model_line = '0;
    int aw_count = 0;
    int w_count = 0;
    int b_count = 0;
    int irq_count = 0;
    int bursts_sent = 0;
    int words_accepted = 0;
    int aw_stall = 0;
    int w_stall = 0;
    logic ddr_enabled = 1'b0;
    logic done_written = 1'b0;
    logic partial_written = 1'b0;

    app_top #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) app_top_i (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(input string msg);
        $display("Fail %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic app_pkg::line_t random_line();
        app_pkg::line_t l;
        int i;
        for (i = 0; i < 16; i++)
            l[i*32 +: 32] = $urandom;
        return l;
    endfunction

    function automatic app_pkg::csr_addr_t reg_addr(input app_pkg::csr_index_e idx);
        return {idx, 2'b00};
    endfunction

    task automatic push_line(input app_pkg::line_t word);
        int b;
        for (b = 0; b < app_pkg::BEATS_PER_LINE; b++)
            exp_q.push_back(word[b*app_pkg::BEAT_WIDTH +: app_pkg::BEAT_WIDTH]);
    endtask

    // random ready with occasional long stalls
    task automatic next_ready(inout int stall, output logic ready);
        if (stall > 0) begin
            stall--;
            ready = 1'b0;
        end else if ($urandom % 16 == 0) begin
            stall = 8 + $urandom % 32;
            ready = 1'b0;
        end else begin
            ready = ($urandom % 2) == 1;
        end
    endtask

    always @(negedge clk) begin
        next_ready(aw_stall, ddr_awready);
        next_ready(w_stall, ddr_wready);
    end

    task automatic check_line();
        app_pkg::line_t exp;
        int n;
        int i;
        assert (w_count < aw_count) else report_error("DDR data without an address");
        if (exp_q.size() >= app_pkg::BEATS_PER_LINE) begin
            n = app_pkg::BEATS_PER_LINE;
        end else begin
            assert (done_written && !partial_written && exp_q.size() > 0)
                else report_error("DDR write with fewer than eight beats queued");
            n = exp_q.size();
            partial_written = 1'b1;
        end
        // unfilled slots keep the previous line
        exp = model_line;
        for (i = 0; i < n; i++)
            exp[i*app_pkg::BEAT_WIDTH +: app_pkg::BEAT_WIDTH] = exp_q.pop_front();
        assert (ddr_wdata == exp)
            else report_error($sformatf("DDR line %0d data mismatch", w_count));
        model_line = exp;
        w_count++;
    endtask

    always @(posedge clk) begin
        if (rstn) begin
            if (ddr_awvalid && ddr_awready) begin
                assert (ddr_awaddr == app_pkg::ddr_addr_t'(aw_count) * app_pkg::LINE_BYTES)
                    else report_error($sformatf("DDR address %0h, line %0d", ddr_awaddr,
                                                aw_count));
                aw_count++;
            end
            if (ddr_wvalid && ddr_wready)
                check_line();
            if (pcis_bvalid && pcis_bready)
                b_count++;
            if (irq_req)
                irq_count++;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
                     !ddr_enabled |-> !ddr_awvalid && !ddr_wvalid)
        else report_error("DDR write while allow_ddr_w is clear");
    assert property (@(posedge clk) disable iff (!rstn) irq_req |-> partial_written)
        else report_error("irq_req before the partial line was written");
    assert property (@(posedge clk) disable iff (!rstn) irq_req |=> !irq_req)
        else report_error("irq_req longer than one cycle");
    assert property (@(posedge clk) disable iff (!rstn) partial_written |-> !ddr_awvalid)
        else report_error("DDR address after the drain");

    task automatic csr_write(input app_pkg::csr_addr_t addr, input app_pkg::csr_word_t data,
                             output int resp_cycles);
        @(negedge clk);
        ocl_awvalid = 1'b1;
        ocl_awaddr = addr;
        @(posedge clk);
        while (!ocl_awready) @(posedge clk);
        @(negedge clk);
        ocl_awvalid = 1'b0;
        ocl_wvalid = 1'b1;
        ocl_wdata = data;
        @(posedge clk);
        while (!ocl_wready) @(posedge clk);
        @(negedge clk);
        ocl_wvalid = 1'b0;
        resp_cycles = 1;
        @(posedge clk);
        while (!ocl_bvalid) begin
            @(posedge clk);
            resp_cycles++;
        end
    endtask

    task automatic pcis_burst(input app_pkg::axi_id_t id, input app_pkg::burst_len_t len);
        app_pkg::line_t word;
        int k;
        @(negedge clk);
        pcis_awvalid = 1'b1;
        pcis_awid = id;
        pcis_awlen = len;
        @(posedge clk);
        while (!pcis_awready) @(posedge clk);
        @(negedge clk);
        pcis_awvalid = 1'b0;
        for (k = 0; k <= int'(len); k++) begin
            word = random_line();
            pcis_wvalid = 1'b1;
            pcis_wdata = word;
            @(posedge clk);
            while (!pcis_wready) @(posedge clk);
            push_line(word);
            words_accepted++;
            @(negedge clk);
        end
        pcis_wvalid = 1'b0;
        @(posedge clk);
        while (!pcis_bvalid) @(posedge clk);
        assert (pcis_bid == id) else report_error($sformatf("bid %0h, awid %0h", pcis_bid, id));
        bursts_sent++;
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    initial begin
        #(20 * STIM_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within the expected number of cycles");
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        int resp;
        int n;
        app_pkg::csr_word_t word;
        void'($urandom(32'h98abeb14));
        rstn = 1'b0;
        {pcis_awvalid, pcis_wvalid, ocl_awvalid, ocl_wvalid} = '0;
        pcis_awid = '0;
        pcis_awlen = '0;
        pcis_wdata = '0;
        ocl_awaddr = '0;
        ocl_wdata = '0;
        pcis_bready = 1'b1;
        ocl_bready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        assert (!pcis_bvalid && !ocl_bvalid && !ddr_awvalid && !ddr_wvalid && !irq_req)
            else report_error("outputs not low after reset");

        // host words back up while DDR writes are off
        fork
            pcis_burst(6'h11, 8'd4);
            begin
                repeat (60) @(posedge clk);
                assert (!pcis_wready && words_accepted == HELD_WORDS)
                    else report_error($sformatf("%0d words taken with DDR off",
                                                words_accepted));
                ddr_enabled = 1'b1;
                csr_write(reg_addr(app_pkg::CSR_ALLOW_DDR_W), 32'h1, resp);
            end
        join
        for (n = 0; n < NUM_BURSTS; n++)
            pcis_burst(app_pkg::axi_id_t'($urandom), app_pkg::burst_len_t'($urandom % 4));
        wait_drained();

        // eight injects make one line
        for (n = 0; n < app_pkg::BEATS_PER_LINE; n++) begin
            word = $urandom;
            exp_q.push_back({32'd0, word});
            csr_write(reg_addr(app_pkg::CSR_INJECT), word, resp);
        end
        wait_drained();

        csr_write(reg_addr(app_pkg::CSR_RESERVED), $urandom, resp);
        assert (resp == 1) else report_error("late response for register 0");
        csr_write(32'h100, $urandom, resp);
        assert (resp == 1) else report_error("late response for an unmapped register");

        // partial line followed by done
        for (n = 0; n < 3; n++) begin
            word = $urandom;
            exp_q.push_back({32'd0, word});
            csr_write(reg_addr(app_pkg::CSR_INJECT), word, resp);
        end
        done_written = 1'b1;
        csr_write(reg_addr(app_pkg::CSR_DONE), 32'h1, resp);
        @(posedge clk);
        while (irq_count == 0) @(posedge clk);
        repeat (100) @(posedge clk);
        assert (irq_count == 1 && partial_written && exp_q.size() == 0)
            else report_error($sformatf("irq count %0d after the drain", irq_count));
        assert (b_count == bursts_sent)
            else report_error($sformatf("%0d B responses for %0d bursts", b_count,
                                        bursts_sent));

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: verilog/app_top.sv
`timescale 1ns/1ps

module app_top #(
    parameter int FIFO_ADDR_WIDTH = 4
) (
    input logic clk,
    input logic rstn,
    input logic pcis_awvalid,
    output logic pcis_awready,
    input app_pkg::axi_id_t pcis_awid,
    input app_pkg::burst_len_t pcis_awlen,
    input logic pcis_wvalid,
    output logic pcis_wready,
    input app_pkg::line_t pcis_wdata,
    output logic pcis_bvalid,
    input logic pcis_bready,
    output app_pkg::axi_id_t pcis_bid,
    input logic ocl_awvalid,
    output logic ocl_awready,
    input app_pkg::csr_addr_t ocl_awaddr,
    input logic ocl_wvalid,
    output logic ocl_wready,
    input app_pkg::csr_word_t ocl_wdata,
    output logic ocl_bvalid,
    input logic ocl_bready,
    output logic ddr_awvalid,
    input logic ddr_awready,
    output app_pkg::ddr_addr_t ddr_awaddr,
    output logic ddr_wvalid,
    input logic ddr_wready,
    output app_pkg::line_t ddr_wdata,
    output logic irq_req
);

    logic app_done;
    logic allow_ddr_w;
    logic sources_idle;

    stream_if pcis_stream ();
    stream_if inject_stream ();
    stream_if merged_stream ();
    stream_if line_stream ();

    pcis_ingest pcis_ingest_i (
        .clk(clk), .rstn(rstn),
        .awvalid(pcis_awvalid), .awready(pcis_awready),
        .awid(pcis_awid), .awlen(pcis_awlen),
        .wvalid(pcis_wvalid), .wready(pcis_wready), .wdata(pcis_wdata),
        .bvalid(pcis_bvalid), .bready(pcis_bready), .bid(pcis_bid),
        .stream(pcis_stream.source)
    );

    ocl_csr ocl_csr_i (
        .clk(clk), .rstn(rstn),
        .awvalid(ocl_awvalid), .awready(ocl_awready), .awaddr(ocl_awaddr),
        .wvalid(ocl_wvalid), .wready(ocl_wready), .wdata(ocl_wdata),
        .bvalid(ocl_bvalid), .bready(ocl_bready),
        .stream(inject_stream.source),
        .app_done(app_done), .allow_ddr_w(allow_ddr_w)
    );

    // inject beats win over host words
    stream_arbiter stream_arbiter_i (
        .clk(clk), .rstn(rstn),
        .high(inject_stream.sink), .low(pcis_stream.sink),
        .out(merged_stream.source), .sources_idle(sources_idle)
    );

    stream_fifo #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) stream_fifo_i (
        .clk(clk), .rstn(rstn),
        .in(merged_stream.sink), .out(line_stream.source)
    );

    ddr_line_writer ddr_line_writer_i (
        .clk(clk), .rstn(rstn),
        .in(line_stream.sink),
        .app_done(app_done), .allow_ddr_w(allow_ddr_w), .sources_idle(sources_idle),
        .awvalid(ddr_awvalid), .awready(ddr_awready), .awaddr(ddr_awaddr),
        .wvalid(ddr_wvalid), .wready(ddr_wready), .wdata(ddr_wdata),
        .irq_req(irq_req)
    );

endmodule

// File: ddr_writer/ddr_line_writer.sv
`timescale 1ns/1ps

module ddr_line_writer (
    input logic clk,
    input logic rstn,
    stream_if.sink in,
    input logic app_done,
    input logic allow_ddr_w,
    input logic sources_idle,
    output logic awvalid,
    input logic awready,
    output app_pkg::ddr_addr_t awaddr,
    output logic wvalid,
    input logic wready,
    output app_pkg::line_t wdata,
    output logic irq_req
);

    app_pkg::writer_state_e state;
    app_pkg::ddr_addr_t addr_q;
    app_pkg::line_t line_q;
    app_pkg::beat_idx_t beat_idx;
    logic beat_fire;
    logic last_beat;
    logic drain;
    logic flush_now;
    logic flushed;
    logic irq_sent;

    assign beat_fire = in.tvalid && in.tready;
    assign last_beat = (beat_idx == app_pkg::beat_idx_t'(app_pkg::BEATS_PER_LINE - 1));

    // nothing left upstream once done is set
    assign drain = app_done && sources_idle && !in.tvalid;
    // an outstanding AW is allowed to finish first
    assign flush_now = drain && !flushed && !wvalid && (state != app_pkg::WR_WAIT_AW);

    assign awvalid = (state == app_pkg::WR_WAIT_AW);
    assign awaddr = addr_q;
    assign wdata = line_q;
    assign in.tready = (state == app_pkg::WR_WAIT_W) && !wvalid && allow_ddr_w;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= app_pkg::WR_IDLE;
            addr_q <= '0;
        end else begin
            case (state)
                app_pkg::WR_IDLE:
                    if (allow_ddr_w && !flushed)
                        state <= app_pkg::WR_WAIT_AW;
                app_pkg::WR_WAIT_AW:
                    if (awready) begin
                        addr_q <= addr_q + app_pkg::ddr_addr_t'(app_pkg::LINE_BYTES);
                        state <= app_pkg::WR_WAIT_W;
                    end
                app_pkg::WR_WAIT_W:
                    if (wvalid && wready)
                        state <= (allow_ddr_w && !flushed) ? app_pkg::WR_WAIT_AW
                                                           : app_pkg::WR_IDLE;
                    else if (flush_now && beat_idx == '0)
                        state <= app_pkg::WR_IDLE;
                default:
                    state <= app_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_idx <= '0;
            wvalid <= 1'b0;
            flushed <= 1'b0;
        end else if (beat_fire) begin
            beat_idx <= beat_idx + 1'b1;
            if (last_beat)
                wvalid <= 1'b1;
        end else if (flush_now) begin
            // partial line goes out once, stale slots included
            wvalid <= (beat_idx != '0);
            beat_idx <= '0;
            flushed <= 1'b1;
        end else if (wvalid && wready) begin
            wvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire)
            line_q[beat_idx * app_pkg::BEAT_WIDTH +: app_pkg::BEAT_WIDTH] <= in.tdata;
    end

    // single pulse once the last write has gone
    always_ff @(posedge clk) begin
        if (!rstn) begin
            irq_req <= 1'b0;
            irq_sent <= 1'b0;
        end else begin
            irq_req <= flushed && !wvalid && !irq_sent;
            if (flushed && !wvalid)
                irq_sent <= 1'b1;
        end
    end

endmodule

// File: verilog/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter int FIFO_ADDR_WIDTH = 4
) (
    input logic clk,
    input logic rstn,
    stream_if.sink in,
    stream_if.source out
);

    localparam int DEPTH = 1 << FIFO_ADDR_WIDTH;

    app_pkg::beat_t data_mem [DEPTH];
    logic last_mem [DEPTH];
    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] wr_next;
    logic full;
    logic empty;
    logic push;
    logic pop;

    assign wr_next = wr_ptr + 1'b1;
    // equal pointers mean empty unless the full flag says otherwise
    assign empty = (wr_ptr == rd_ptr) && !full;
    assign push = in.tvalid && in.tready;
    assign pop = out.tvalid && out.tready;

    assign in.tready = !full;
    assign out.tvalid = !empty;
    assign out.tdata = data_mem[rd_ptr];
    assign out.tlast = last_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in.tdata;
            last_mem[wr_ptr] <= in.tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_next;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                full <= (wr_next == rd_ptr);
            else if (pop && !push)
                full <= 1'b0;
        end
    end

endmodule

// File: verilog/stream_arbiter.sv
`timescale 1ns/1ps

module stream_arbiter (
    input logic clk,
    input logic rstn,
    stream_if.sink high,
    stream_if.sink low,
    stream_if.source out,
    output logic sources_idle
);

    app_pkg::arb_state_e state;
    logic sel_high;
    logic out_fire;

    // idle picks high when it has data, otherwise stay on the locked input
    assign sel_high = (state == app_pkg::ARB_HIGH) ||
                      (state == app_pkg::ARB_IDLE && high.tvalid);
    assign out_fire = out.tvalid && out.tready;

    assign out.tdata = sel_high ? high.tdata : low.tdata;
    assign out.tlast = sel_high ? high.tlast : low.tlast;
    assign out.tvalid = sel_high ? high.tvalid : low.tvalid;
    assign high.tready = sel_high && out.tready;
    assign low.tready = !sel_high && out.tready;

    assign sources_idle = !high.tvalid && !low.tvalid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= app_pkg::ARB_IDLE;
        end else begin
            case (state)
                app_pkg::ARB_IDLE:
                    // lock only for packets longer than one beat
                    if (out_fire && !out.tlast)
                        state <= sel_high ? app_pkg::ARB_HIGH : app_pkg::ARB_LOW;
                app_pkg::ARB_HIGH,
                app_pkg::ARB_LOW:
                    if (out_fire && out.tlast)
                        state <= app_pkg::ARB_IDLE;
                default:
                    state <= app_pkg::ARB_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/ocl_csr.sv
`timescale 1ns/1ps

module ocl_csr (
    input logic clk,
    input logic rstn,
    input logic awvalid,
    output logic awready,
    input app_pkg::csr_addr_t awaddr,
    input logic wvalid,
    output logic wready,
    input app_pkg::csr_word_t wdata,
    output logic bvalid,
    input logic bready,
    stream_if.source stream,
    output logic app_done,
    output logic allow_ddr_w
);

    app_pkg::csr_state_e state;
    app_pkg::csr_addr_t addr_q;
    app_pkg::csr_word_t inject_word;
    logic [29:0] word_idx;
    logic is_inject;
    logic aw_fire;
    logic w_fire;

    assign aw_fire = awvalid && awready;
    assign w_fire = wvalid && wready;

    // misaligned addresses fall onto the reserved word
    assign word_idx = (addr_q[1:0] == 2'b00) ? addr_q[31:2] : app_pkg::CSR_RESERVED;
    assign is_inject = (word_idx == app_pkg::CSR_INJECT);

    assign awready = (state == app_pkg::CSR_ST_IDLE);
    assign wready = (state == app_pkg::CSR_ST_WAIT_W);
    assign bvalid = (state == app_pkg::CSR_ST_RESP);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= app_pkg::CSR_ST_IDLE;
            app_done <= 1'b0;
            allow_ddr_w <= 1'b0;
        end else begin
            case (state)
                app_pkg::CSR_ST_IDLE:
                    if (aw_fire)
                        state <= app_pkg::CSR_ST_WAIT_W;
                app_pkg::CSR_ST_WAIT_W:
                    if (w_fire) begin
                        if (word_idx == app_pkg::CSR_DONE)
                            app_done <= 1'b1;
                        if (word_idx == app_pkg::CSR_ALLOW_DDR_W)
                            allow_ddr_w <= wdata[0];
                        // inject holds the response until its beat is taken
                        if (is_inject)
                            state <= app_pkg::CSR_ST_INJECT;
                        else
                            state <= app_pkg::CSR_ST_RESP;
                    end
                app_pkg::CSR_ST_INJECT:
                    if (stream.tready)
                        state <= app_pkg::CSR_ST_RESP;
                app_pkg::CSR_ST_RESP:
                    if (bready)
                        state <= app_pkg::CSR_ST_IDLE;
                default:
                    state <= app_pkg::CSR_ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire)
            addr_q <= awaddr;
        if (w_fire)
            inject_word <= wdata;
    end

    // single-beat packet, zero extended
    assign stream.tdata = app_pkg::beat_t'(inject_word);
    assign stream.tlast = 1'b1;
    assign stream.tvalid = (state == app_pkg::CSR_ST_INJECT);

endmodule

// File: pcis_ingest/pcis_ingest.sv
`timescale 1ns/1ps

module pcis_ingest (
    input logic clk,
    input logic rstn,
    input logic awvalid,
    output logic awready,
    input app_pkg::axi_id_t awid,
    input app_pkg::burst_len_t awlen,
    input logic wvalid,
    output logic wready,
    input app_pkg::line_t wdata,
    output logic bvalid,
    input logic bready,
    output app_pkg::axi_id_t bid,
    stream_if.source stream
);

    app_pkg::pcis_aw_state_e aw_state;
    app_pkg::pcis_w_state_e w_state;
    app_pkg::burst_len_t remaining;
    app_pkg::axi_id_t id_q;
    app_pkg::line_t line_q;
    app_pkg::beat_idx_t beat_idx;
    logic aw_fire;
    logic w_fire;
    logic beat_fire;

    assign aw_fire = awvalid && awready;
    assign w_fire = wvalid && wready;
    assign beat_fire = stream.tvalid && stream.tready;

    assign awready = (aw_state == app_pkg::AW_IDLE);
    // one word at a time, next word only after the last beat went out
    assign wready = (aw_state == app_pkg::AW_WAIT_W) && (w_state == app_pkg::W_IDLE);
    assign bvalid = (aw_state == app_pkg::AW_SEND_B);
    assign bid = id_q;

    // address and response side
    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_state <= app_pkg::AW_IDLE;
        end else begin
            case (aw_state)
                app_pkg::AW_IDLE:
                    if (aw_fire)
                        aw_state <= app_pkg::AW_WAIT_W;
                app_pkg::AW_WAIT_W:
                    if (w_fire && remaining == '0)
                        aw_state <= app_pkg::AW_SEND_B;
                app_pkg::AW_SEND_B:
                    if (bready)
                        aw_state <= app_pkg::AW_IDLE;
                default:
                    aw_state <= app_pkg::AW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            remaining <= awlen;
            id_q <= awid;
        end else if (w_fire) begin
            remaining <= remaining - 1'b1;
        end
    end

    // data side, word to eight beats
    always_ff @(posedge clk) begin
        if (!rstn) begin
            w_state <= app_pkg::W_IDLE;
            beat_idx <= '0;
        end else begin
            if (beat_fire)
                beat_idx <= beat_idx + 1'b1;
            case (w_state)
                app_pkg::W_IDLE:
                    if (w_fire)
                        w_state <= app_pkg::W_SERIALIZE;
                app_pkg::W_SERIALIZE:
                    if (beat_fire && stream.tlast)
                        w_state <= app_pkg::W_IDLE;
                default:
                    w_state <= app_pkg::W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (w_fire)
            line_q <= wdata;
    end

    // lowest beat first
    assign stream.tdata = line_q[beat_idx * app_pkg::BEAT_WIDTH +: app_pkg::BEAT_WIDTH];
    assign stream.tlast = (beat_idx == app_pkg::beat_idx_t'(app_pkg::BEATS_PER_LINE - 1));
    assign stream.tvalid = (w_state == app_pkg::W_SERIALIZE);

endmodule

// File: common/stream_if.sv
`timescale 1ns/1ps

interface stream_if;

    app_pkg::beat_t tdata;
    logic tvalid;
    logic tready;
    logic tlast;

    modport source (
        output tdata, tvalid, tlast,
        input tready
    );

    modport sink (
        input tdata, tvalid, tlast,
        output tready
    );

endinterface

// File: common/app_pkg.sv
package app_pkg;

    localparam int BEAT_WIDTH = 64;
    localparam int LINE_WIDTH = 512;
    localparam int BEATS_PER_LINE = LINE_WIDTH / BEAT_WIDTH;
    localparam int LINE_BYTES = LINE_WIDTH / 8;

    typedef logic [BEAT_WIDTH-1:0] beat_t;
    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;
    typedef logic [63:0] ddr_addr_t;
    typedef logic [31:0] csr_addr_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [5:0] axi_id_t;
    typedef logic [7:0] burst_len_t;

    // register word index, byte address is index * 4
    typedef enum logic [29:0] {
        CSR_RESERVED = 30'd0,
        CSR_DONE = 30'd1,
        CSR_INJECT = 30'd2,
        CSR_ALLOW_DDR_W = 30'd3
    } csr_index_e;

    typedef enum logic [1:0] {AW_IDLE, AW_WAIT_W, AW_SEND_B} pcis_aw_state_e;
    typedef enum logic {W_IDLE, W_SERIALIZE} pcis_w_state_e;

    typedef enum logic [1:0] {
        CSR_ST_IDLE,
        CSR_ST_WAIT_W,
        CSR_ST_INJECT,
        CSR_ST_RESP
    } csr_state_e;

    typedef enum logic [1:0] {ARB_IDLE, ARB_HIGH, ARB_LOW} arb_state_e;

    typedef enum logic [1:0] {WR_IDLE, WR_WAIT_AW, WR_WAIT_W} writer_state_e;

endpackage
